// File: Makefile
# Verilator simulation of the instruction cache

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
hw/icache_pkg.sv
hw/icache_data_bank.sv
hw/icache_bank_ctrl.sv
hw/icache_tag_lookup.sv
hw/icache_word_select.sv
hw/icache_miss_ctrl.sv
hw/icache_top.sv
test/icache_tb.sv

// File: hw/icache_bank_ctrl.sv
// Data bank address and write control
`timescale 1ns/10ps
`default_nettype none

module icache_bank_ctrl
  (
    input  logic                                           fetch_accept_i,
    input  icache_pkg::vaddr_t                             vaddr_i,

    input  icache_pkg::data_pkt_s                          data_pkt_i,
    input  logic                                           data_pkt_v_i,
    output logic                                           data_pkt_yumi_o,

    output logic [icache_pkg::ASSOC-1:0]                   bank_v_o,
    output logic [icache_pkg::ASSOC-1:0]                   bank_w_o,
    output icache_pkg::bank_addr_s [icache_pkg::ASSOC-1:0] bank_addr_o,
    output icache_pkg::word_t [icache_pkg::ASSOC-1:0]      bank_data_o
  );

  icache_pkg::bank_addr_s fetch_addr;

  // Every bank reads the same slot on a fetch
  assign fetch_addr.index = vaddr_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
  assign fetch_addr.slot  = vaddr_i[icache_pkg::BYTE_W +: icache_pkg::OFFSET_W];

  // Fills wait for a cycle without a fetch
  assign data_pkt_yumi_o = data_pkt_v_i & ~fetch_accept_i;

  ////////////////////////////////////////////////////////////////////////////
  // Per-bank control
  ////////////////////////////////////////////////////////////////////////////
  for (genvar b = 0; b < icache_pkg::ASSOC; b++)
    begin : g_bank
      icache_pkg::offset_t    fill_slot;
      icache_pkg::bank_addr_s fill_addr;

      // Word w of way h lives in bank h+w, so bank b holds word b-h
      assign fill_slot       = icache_pkg::offset_t'(b) - data_pkt_i.way_id;
      assign fill_addr.index = data_pkt_i.index;
      assign fill_addr.slot  = fill_slot;

      assign bank_v_o[b]    = fetch_accept_i | data_pkt_yumi_o;
      assign bank_w_o[b]    = data_pkt_yumi_o;
      assign bank_addr_o[b] = fetch_accept_i ? fetch_addr : fill_addr;
      assign bank_data_o[b] = data_pkt_i.data[fill_slot];
    end

endmodule

`default_nettype wire

// File: hw/icache_data_bank.sv
// Single-port instruction data bank
`timescale 1ns/10ps
`default_nettype none

module icache_data_bank
  (
    input  logic                   clk_i,
    input  logic                   v_i,
    input  logic                   w_i,
    input  icache_pkg::bank_addr_s addr_i,
    input  icache_pkg::word_t      data_i,
    output icache_pkg::word_t      data_o
  );

  // One word per way slot of every set
  icache_pkg::word_t mem [icache_pkg::SETS*icache_pkg::ASSOC];

  // Read data stays put until the next read
  always_ff @(posedge clk_i)
    begin
      if (v_i)
        begin
          if (w_i)
            mem[addr_i] <= data_i;
          else
            data_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_miss_ctrl.sv
// Miss control and replacement
`timescale 1ns/10ps
`default_nettype none

module icache_miss_ctrl
  (
    input  logic                     clk_i,
    input  logic                     reset_i,

    input  logic                     v_i,
    output logic                     ready_o,
    output logic                     fetch_accept_o,

    input  icache_pkg::tl_info_s     tl_info_i,
    input  logic                     tl_valid_i,
    output logic                     tv_en_o,

    output logic                     data_v_o,
    output logic                     miss_v_o,

    output icache_pkg::icache_req_s  cache_req_o,
    output logic                     cache_req_v_o,
    input  logic                     cache_req_yumi_i,
    input  logic                     cache_req_busy_i,
    input  logic                     cache_req_complete_i
  );

  typedef enum logic {e_ready, e_miss} state_e;

  state_e                                state_r;
  logic                                  tv_v_r;
  icache_pkg::tl_info_s                  tv_info_r;
  icache_pkg::lru_s [icache_pkg::SETS-1:0] lru_r;

  icache_pkg::index_t                    tv_index;
  icache_pkg::lru_s                      tv_lru;
  icache_pkg::way_t                      hit_way;
  icache_pkg::way_t                      inv_way;
  logic                                  inv_found;
  icache_pkg::way_t                      repl_way;

  ////////////////////////////////////////////////////////////////////////////
  // Ready / miss FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        state_r <= e_ready;
      else if (state_r == e_ready && cache_req_yumi_i)
        state_r <= e_miss;
      else if (state_r == e_miss && cache_req_complete_i)
        state_r <= e_ready;
    end

  assign ready_o        = (state_r == e_ready) & ~cache_req_busy_i;
  assign fetch_accept_o = v_i & ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // TV stage
  ////////////////////////////////////////////////////////////////////////////
  assign tv_en_o = tl_valid_i;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        tv_v_r <= 1'b0;
      else
        tv_v_r <= tl_valid_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (tl_valid_i)
        tv_info_r <= tl_info_i;
    end

  assign data_v_o      = tv_v_r & tv_info_r.hit;
  assign miss_v_o      = tv_v_r & ~tv_info_r.hit;
  assign cache_req_v_o = miss_v_o;

  assign cache_req_o.paddr    = tv_info_r.paddr;
  assign cache_req_o.repl_way = repl_way;

  ////////////////////////////////////////////////////////////////////////////
  // Pseudo-tree LRU
  ////////////////////////////////////////////////////////////////////////////
  assign tv_index = tv_info_r.paddr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];
  assign tv_lru   = lru_r[tv_index];

  always_comb
    begin
      hit_way   = '0;
      inv_way   = '0;
      inv_found = 1'b0;
      for (int i = 0; i < icache_pkg::ASSOC; i++)
        if (tv_info_r.hit_ways[i])
          hit_way = icache_pkg::way_t'(i);
      // Walk downward so the lowest invalid way wins
      for (int i = icache_pkg::ASSOC - 1; i >= 0; i--)
        if (!tv_info_r.valid_ways[i])
          begin
            inv_way   = icache_pkg::way_t'(i);
            inv_found = 1'b1;
          end
    end

  assign repl_way = inv_found ? inv_way
                  : {tv_lru.root, (tv_lru.root ? tv_lru.node1 : tv_lru.node0)};

  // Point the tree away from the way just hit
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        lru_r <= '0;
      else if (data_v_o)
        begin
          lru_r[tv_index].root <= ~hit_way[1];
          if (hit_way[1])
            lru_r[tv_index].node1 <= ~hit_way[0];
          else
            lru_r[tv_index].node0 <= ~hit_way[0];
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_pkg.sv
// Instruction cache shared definitions
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////
  localparam int ASSOC      = 4;
  localparam int SETS       = 16;
  localparam int WORD_W     = 32;
  localparam int BLOCK_W    = ASSOC * WORD_W;
  localparam int WAY_W      = 2;
  localparam int INDEX_W    = 4;
  localparam int OFFSET_W   = 2;
  localparam int BYTE_W     = 2;
  localparam int PTAG_W     = 8;
  localparam int VADDR_W    = 16;

  // Address field positions
  localparam int INDEX_LSB  = OFFSET_W + BYTE_W;
  localparam int PAGE_OFF_W = INDEX_W + OFFSET_W + BYTE_W;
  localparam int PADDR_W    = PTAG_W + PAGE_OFF_W;

  ////////////////////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [VADDR_W-1:0]  vaddr_t;
  typedef logic [PADDR_W-1:0]  paddr_t;
  typedef logic [PTAG_W-1:0]   ptag_t;
  typedef logic [WAY_W-1:0]    way_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef word_t [BLOCK_W/WORD_W-1:0] block_t;

  // One word slot inside a bank
  typedef struct packed {
    index_t  index;
    offset_t slot;
  } bank_addr_s;

  ////////////////////////////////////////////////////////////////////////////
  // Engine packets
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic {
    e_tag_set,
    e_tag_clear
  } tag_op_e;

  typedef struct packed {
    tag_op_e opcode;
    index_t  index;
    way_t    way_id;
    ptag_t   tag;
  } tag_pkt_s;

  typedef struct packed {
    index_t index;
    way_t   way_id;
    block_t data;
  } data_pkt_s;

  typedef struct packed {
    paddr_t paddr;
    way_t   repl_way;
  } icache_req_s;

  // Lookup result handed from TL to TV
  typedef struct packed {
    paddr_t           paddr;
    logic [ASSOC-1:0] hit_ways;
    logic [ASSOC-1:0] valid_ways;
    logic             hit;
  } tl_info_s;

  // Pseudo-tree LRU bits of one set
  typedef struct packed {
    logic node1;
    logic node0;
    logic root;
  } lru_s;

endpackage

`default_nettype wire

// File: hw/icache_tag_lookup.sv
// Tag array and tag lookup stage
`timescale 1ns/10ps
`default_nettype none

module icache_tag_lookup
  (
    input  logic                  clk_i,
    input  logic                  reset_i,

    input  logic                  fetch_accept_i,
    input  icache_pkg::vaddr_t    vaddr_i,

    input  icache_pkg::ptag_t     ptag_i,
    input  logic                  ptag_v_i,

    input  icache_pkg::tag_pkt_s  tag_pkt_i,
    input  logic                  tag_pkt_v_i,
    output logic                  tag_pkt_yumi_o,

    output icache_pkg::tl_info_s  tl_info_o,
    output logic                  tl_valid_o
  );

  // Valid bits per set and way
  logic [icache_pkg::SETS-1:0][icache_pkg::ASSOC-1:0] valid_r;
  icache_pkg::ptag_t [icache_pkg::ASSOC-1:0]          tag_r [icache_pkg::SETS];

  icache_pkg::index_t                                 rd_index;

  // TL stage state
  logic                                               tl_v_r;
  icache_pkg::vaddr_t                                 tl_vaddr_r;
  icache_pkg::ptag_t [icache_pkg::ASSOC-1:0]          tl_tags_r;
  logic [icache_pkg::ASSOC-1:0]                       tl_ways_v_r;
  logic [icache_pkg::ASSOC-1:0]                       hit_ways;

  assign rd_index = vaddr_i[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_W];

  // Engine writes only slip in when no fetch reads the array
  assign tag_pkt_yumi_o = tag_pkt_v_i & ~fetch_accept_i;

  ////////////////////////////////////////////////////////////////////////////
  // Tag array
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        valid_r <= '0;
      else if (tag_pkt_yumi_o)
        valid_r[tag_pkt_i.index][tag_pkt_i.way_id] <=
          (tag_pkt_i.opcode == icache_pkg::e_tag_set);
    end

  always_ff @(posedge clk_i)
    begin
      if (tag_pkt_yumi_o && tag_pkt_i.opcode == icache_pkg::e_tag_set)
        tag_r[tag_pkt_i.index][tag_pkt_i.way_id] <= tag_pkt_i.tag;
    end

  ////////////////////////////////////////////////////////////////////////////
  // TL stage
  ////////////////////////////////////////////////////////////////////////////
  // Pipeline never stalls, so TL holds only the fetch from the last cycle
  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        tl_v_r <= 1'b0;
      else
        tl_v_r <= fetch_accept_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (fetch_accept_i)
        begin
          tl_vaddr_r  <= vaddr_i;
          tl_tags_r   <= tag_r[rd_index];
          tl_ways_v_r <= valid_r[rd_index];
        end
    end

  // Way compare against the translated tag
  always_comb
    begin
      for (int i = 0; i < icache_pkg::ASSOC; i++)
        hit_ways[i] = tl_ways_v_r[i] & (tl_tags_r[i] == ptag_i);
    end

  assign tl_info_o.paddr      = {ptag_i, tl_vaddr_r[icache_pkg::PAGE_OFF_W-1:0]};
  assign tl_info_o.hit_ways   = hit_ways;
  assign tl_info_o.valid_ways = tl_ways_v_r;
  assign tl_info_o.hit        = |hit_ways;

  assign tl_valid_o = tl_v_r & ptag_v_i;

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// Instruction cache top level
`timescale 1ns/10ps
`default_nettype none

module icache_top
  (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Decode
    input  icache_pkg::vaddr_t       vaddr_i,
    input  logic                     v_i,
    output logic                     ready_o,

    // Tag lookup
    input  icache_pkg::ptag_t        ptag_i,
    input  logic                     ptag_v_i,

    // Tag verify
    output icache_pkg::word_t        data_o,
    output logic                     data_v_o,
    output logic                     miss_v_o,

    // Miss request to the engine
    output icache_pkg::icache_req_s  cache_req_o,
    output logic                     cache_req_v_o,
    input  logic                     cache_req_yumi_i,
    input  logic                     cache_req_busy_i,
    input  logic                     cache_req_complete_i,

    // Engine tag and fill ports
    input  icache_pkg::tag_pkt_s     tag_pkt_i,
    input  logic                     tag_pkt_v_i,
    output logic                     tag_pkt_yumi_o,
    input  icache_pkg::data_pkt_s    data_pkt_i,
    input  logic                     data_pkt_v_i,
    output logic                     data_pkt_yumi_o
  );

  logic                                              fetch_accept;
  icache_pkg::tl_info_s                              tl_info;
  logic                                              tl_valid;
  logic                                              tv_en;

  logic [icache_pkg::ASSOC-1:0]                      bank_v;
  logic [icache_pkg::ASSOC-1:0]                      bank_w;
  icache_pkg::bank_addr_s [icache_pkg::ASSOC-1:0]    bank_addr;
  icache_pkg::word_t [icache_pkg::ASSOC-1:0]         bank_wdata;
  icache_pkg::word_t [icache_pkg::ASSOC-1:0]         bank_rdata;

  icache_tag_lookup tag_lookup_i
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .fetch_accept_i (fetch_accept),
      .vaddr_i        (vaddr_i),
      .ptag_i         (ptag_i),
      .ptag_v_i       (ptag_v_i),
      .tag_pkt_i      (tag_pkt_i),
      .tag_pkt_v_i    (tag_pkt_v_i),
      .tag_pkt_yumi_o (tag_pkt_yumi_o),
      .tl_info_o      (tl_info),
      .tl_valid_o     (tl_valid)
    );

  icache_bank_ctrl bank_ctrl_i
    (
      .fetch_accept_i  (fetch_accept),
      .vaddr_i         (vaddr_i),
      .data_pkt_i      (data_pkt_i),
      .data_pkt_v_i    (data_pkt_v_i),
      .data_pkt_yumi_o (data_pkt_yumi_o),
      .bank_v_o        (bank_v),
      .bank_w_o        (bank_w),
      .bank_addr_o     (bank_addr),
      .bank_data_o     (bank_wdata)
    );

  // Data banks holding the words of each way across all of them
  for (genvar b = 0; b < icache_pkg::ASSOC; b++)
    begin : g_bank
      icache_data_bank data_bank_i
        (
          .clk_i  (clk_i),
          .v_i    (bank_v[b]),
          .w_i    (bank_w[b]),
          .addr_i (bank_addr[b]),
          .data_i (bank_wdata[b]),
          .data_o (bank_rdata[b])
        );
    end

  icache_word_select word_select_i
    (
      .clk_i       (clk_i),
      .tv_en_i     (tv_en),
      .bank_data_i (bank_rdata),
      .tl_info_i   (tl_info),
      .data_o      (data_o)
    );

  icache_miss_ctrl miss_ctrl_i
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .v_i                  (v_i),
      .ready_o              (ready_o),
      .fetch_accept_o       (fetch_accept),
      .tl_info_i            (tl_info),
      .tl_valid_i           (tl_valid),
      .tv_en_o              (tv_en),
      .data_v_o             (data_v_o),
      .miss_v_o             (miss_v_o),
      .cache_req_o          (cache_req_o),
      .cache_req_v_o        (cache_req_v_o),
      .cache_req_yumi_i     (cache_req_yumi_i),
      .cache_req_busy_i     (cache_req_busy_i),
      .cache_req_complete_i (cache_req_complete_i)
    );

endmodule

`default_nettype wire

// File: hw/icache_word_select.sv
// Tag verify word selection
`timescale 1ns/10ps
`default_nettype none

module icache_word_select
  (
    input  logic                                      clk_i,
    input  logic                                      tv_en_i,
    input  icache_pkg::word_t [icache_pkg::ASSOC-1:0] bank_data_i,
    input  icache_pkg::tl_info_s                      tl_info_i,
    output icache_pkg::word_t                         data_o
  );

  icache_pkg::word_t [icache_pkg::ASSOC-1:0] bank_data_r;
  logic [icache_pkg::ASSOC-1:0]              hit_ways_r;
  icache_pkg::offset_t                       offset_r;
  logic [icache_pkg::ASSOC-1:0]              bank_sel;

  // TV capture
  always_ff @(posedge clk_i)
    begin
      if (tv_en_i)
        begin
          bank_data_r <= bank_data_i;
          hit_ways_r  <= tl_info_i.hit_ways;
          offset_r    <= tl_info_i.paddr[icache_pkg::BYTE_W +: icache_pkg::OFFSET_W];
        end
    end

  // Hit one-hot rotated left by the word offset names the bank
  always_comb
    begin
      for (int b = 0; b < icache_pkg::ASSOC; b++)
        bank_sel[b] = hit_ways_r[icache_pkg::way_t'(b) - offset_r];
    end

  always_comb
    begin
      data_o = '0;
      for (int b = 0; b < icache_pkg::ASSOC; b++)
        if (bank_sel[b])
          data_o = data_o | bank_data_r[b];
    end

endmodule

`default_nettype wire

// File: test/icache_tb.sv
// Instruction cache testbench
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

  localparam int CLK_PERIOD = 40;
  localparam int WAIT_LIMIT = 8;

  // One fetch as it moves through TL and TV
  typedef struct packed {
    logic                             v;
    logic                             ptag_v;
    icache_pkg::vaddr_t               vaddr;
    icache_pkg::ptag_t                ptag;
    logic                             hit;
    icache_pkg::way_t                 hit_way;
    logic [icache_pkg::ASSOC-1:0]     valid_ways;
    icache_pkg::word_t                word;
  } fetch_rec_s;

  logic                    clk_i;
  logic                    reset_i;
  icache_pkg::vaddr_t      vaddr_i;
  logic                    v_i;
  logic                    ready_o;
  icache_pkg::ptag_t       ptag_i;
  logic                    ptag_v_i;
  icache_pkg::word_t       data_o;
  logic                    data_v_o;
  logic                    miss_v_o;
  icache_pkg::icache_req_s cache_req_o;
  logic                    cache_req_v_o;
  logic                    cache_req_yumi_i;
  logic                    cache_req_busy_i;
  logic                    cache_req_complete_i;
  icache_pkg::tag_pkt_s    tag_pkt_i;
  logic                    tag_pkt_v_i;
  logic                    tag_pkt_yumi_o;
  icache_pkg::data_pkt_s   data_pkt_i;
  logic                    data_pkt_v_i;
  logic                    data_pkt_yumi_o;

  // Reference model of the cache contents
  logic              model_valid [icache_pkg::SETS][icache_pkg::ASSOC];
  icache_pkg::ptag_t model_tag   [icache_pkg::SETS][icache_pkg::ASSOC];
  icache_pkg::word_t model_word  [icache_pkg::SETS][icache_pkg::ASSOC][icache_pkg::ASSOC];
  logic              lru_root    [icache_pkg::SETS];
  logic              lru_node    [icache_pkg::SETS][2];
  logic              model_miss;

  // Expected outputs of the current cycle
  logic               exp_data_v;
  logic               exp_miss_v;
  logic               exp_ready;
  logic               exp_accept;
  icache_pkg::word_t  exp_word;
  icache_pkg::paddr_t exp_paddr;
  icache_pkg::way_t   exp_repl;

  fetch_rec_s         tl_rec;
  fetch_rec_s         tv_rec;
  icache_pkg::ptag_t  fetch_ptag;
  logic               fetch_ptag_v;
  logic               seen_tag_yumi;
  logic               seen_data_yumi;
  logic               seen_req_v;
  logic               seen_ready;
  icache_pkg::way_t   req_way;
  integer             seed;

  assign exp_ready  = ~model_miss & ~cache_req_busy_i;
  assign exp_accept = v_i & exp_ready;

  icache_top dut_i (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  a_ready: assert property (@(posedge clk_i) disable iff (reset_i) ready_o == exp_ready)
    else value_error("ready_o differs from the model");
  a_data_v: assert property (@(posedge clk_i) disable iff (reset_i) data_v_o == exp_data_v)
    else value_error("data_v_o differs from the model");
  a_miss_v: assert property (@(posedge clk_i) disable iff (reset_i) miss_v_o == exp_miss_v)
    else value_error("miss_v_o differs from the model");
  a_req_v: assert property (@(posedge clk_i) disable iff (reset_i)
                            cache_req_v_o == exp_miss_v)
    else value_error("cache_req_v_o differs from the model");
  a_data: assert property (@(posedge clk_i) disable iff (reset_i)
                           exp_data_v |-> data_o == exp_word)
    else value_error($sformatf("data_o %h, expected %h", $sampled(data_o),
                               $sampled(exp_word)));
  a_req: assert property (@(posedge clk_i) disable iff (reset_i)
                          exp_miss_v |-> (cache_req_o.paddr == exp_paddr &&
                                          cache_req_o.repl_way == exp_repl))
    else value_error($sformatf("miss request %h/%0d, expected %h/%0d",
                               $sampled(cache_req_o.paddr), $sampled(cache_req_o.repl_way),
                               $sampled(exp_paddr), $sampled(exp_repl)));
  a_tag_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
                               tag_pkt_yumi_o == (tag_pkt_v_i & ~exp_accept))
    else value_error("tag_pkt_yumi_o differs from the model");
  a_data_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
                                data_pkt_yumi_o == (data_pkt_v_i & ~exp_accept))
    else value_error("data_pkt_yumi_o differs from the model");

  task automatic stop_failed;
    begin
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic value_error(input string what);
    begin
      $display("[FAIL] time %0d ns: %s", $time, what);
      stop_failed();
    end
  endtask

  task automatic wait_expired(input string what);
    begin
      $display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, what);
      stop_failed();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////////////////////
  // Hit, valid ways and word as seen when the fetch reads the arrays
  function automatic fetch_rec_s lookup(input logic v, input icache_pkg::vaddr_t va,
                                        input icache_pkg::ptag_t pt, input logic pv);
    fetch_rec_s rec;
    int         idx;
    begin
      rec        = '0;
      idx        = int'(va[7:4]);
      rec.v      = v;
      rec.ptag_v = pv;
      rec.vaddr  = va;
      rec.ptag   = pt;
      for (int w = 0; w < icache_pkg::ASSOC; w++)
        begin
          rec.valid_ways[w] = model_valid[idx][w];
          if (model_valid[idx][w] && model_tag[idx][w] == pt)
            begin
              rec.hit     = 1'b1;
              rec.hit_way = icache_pkg::way_t'(w);
              rec.word    = model_word[idx][w][va[3:2]];
            end
        end
      return rec;
    end
  endfunction

  // Lowest invalid way, else the way the tree points at
  function automatic icache_pkg::way_t choose_victim(input fetch_rec_s rec);
    icache_pkg::way_t victim;
    logic             found;
    int               idx;
    begin
      idx    = int'(rec.vaddr[7:4]);
      found  = 1'b0;
      victim = {lru_root[idx], lru_node[idx][lru_root[idx]]};
      for (int w = 0; w < icache_pkg::ASSOC; w++)
        if (!found && !rec.valid_ways[w])
          begin
            victim = icache_pkg::way_t'(w);
            found  = 1'b1;
          end
      return victim;
    end
  endfunction

  // One clock cycle; called and returning at a falling edge
  task automatic step;
    fetch_rec_s new_rec;
    logic       do_tag;
    logic       do_data;
    int         idx;
    begin
      #(CLK_PERIOD/4);
      seen_tag_yumi  = tag_pkt_yumi_o;
      seen_data_yumi = data_pkt_yumi_o;
      new_rec = lookup(exp_accept, vaddr_i, fetch_ptag, fetch_ptag_v);
      do_tag  = tag_pkt_v_i & ~exp_accept;
      do_data = data_pkt_v_i & ~exp_accept;
      @(posedge clk_i);
      if (do_tag)
        begin
          model_valid[tag_pkt_i.index][tag_pkt_i.way_id] =
            (tag_pkt_i.opcode == icache_pkg::e_tag_set);
          model_tag[tag_pkt_i.index][tag_pkt_i.way_id] = tag_pkt_i.tag;
        end
      if (do_data)
        for (int i = 0; i < icache_pkg::ASSOC; i++)
          model_word[data_pkt_i.index][data_pkt_i.way_id][i] = data_pkt_i.data[i];
      // Tree points away from the way just hit
      if (exp_data_v)
        begin
          idx = int'(tv_rec.vaddr[7:4]);
          lru_root[idx] = ~tv_rec.hit_way[1];
          lru_node[idx][tv_rec.hit_way[1]] = ~tv_rec.hit_way[0];
        end
      if (!model_miss && cache_req_yumi_i)
        model_miss = 1'b1;
      else if (model_miss && cache_req_complete_i)
        model_miss = 1'b0;
      @(negedge clk_i);
      seen_req_v = cache_req_v_o;
      seen_ready = ready_o;
      tv_rec     = tl_rec;
      tv_rec.v   = tl_rec.v & tl_rec.ptag_v;
      tl_rec     = new_rec;
      exp_data_v = tv_rec.v & tv_rec.hit;
      exp_miss_v = tv_rec.v & ~tv_rec.hit;
      exp_word   = tv_rec.word;
      exp_paddr  = {tv_rec.ptag, tv_rec.vaddr[7:0]};
      exp_repl   = choose_victim(tv_rec);
      ptag_i     = tl_rec.ptag;
      ptag_v_i   = tl_rec.v & tl_rec.ptag_v;
      v_i                  = 1'b0;
      cache_req_yumi_i     = 1'b0;
      cache_req_complete_i = 1'b0;
      tag_pkt_v_i          = 1'b0;
      data_pkt_v_i         = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic issue_fetch(input icache_pkg::index_t idx, input icache_pkg::offset_t off,
                             input icache_pkg::ptag_t pt, input logic pv);
    logic [31:0] rnd;
    begin
      rnd          = $random(seed);
      v_i          = 1'b1;
      vaddr_i      = {rnd[7:0], idx, off, 2'b00};
      fetch_ptag   = pt;
      fetch_ptag_v = pv;
      step();
    end
  endtask

  task automatic write_tag(input icache_pkg::tag_op_e op, input icache_pkg::index_t idx,
                           input icache_pkg::way_t way, input icache_pkg::ptag_t pt);
    int tries;
    begin
      tries         = 0;
      seen_tag_yumi = 1'b0;
      while (!seen_tag_yumi)
        begin
          if (tries == WAIT_LIMIT)
            wait_expired("tag write acceptance");
          tag_pkt_i.opcode = op;
          tag_pkt_i.index  = idx;
          tag_pkt_i.way_id = way;
          tag_pkt_i.tag    = pt;
          tag_pkt_v_i      = 1'b1;
          step();
          tries++;
        end
    end
  endtask

  task automatic fill_random(input icache_pkg::index_t idx, input icache_pkg::way_t way);
    icache_pkg::block_t blk;
    int                 tries;
    begin
      for (int i = 0; i < icache_pkg::ASSOC; i++)
        blk[i] = $random(seed);
      tries          = 0;
      seen_data_yumi = 1'b0;
      while (!seen_data_yumi)
        begin
          if (tries == WAIT_LIMIT)
            wait_expired("block fill acceptance");
          data_pkt_i.index  = idx;
          data_pkt_i.way_id = way;
          data_pkt_i.data   = blk;
          data_pkt_v_i      = 1'b1;
          step();
          tries++;
        end
    end
  endtask

  // Engine side of a miss; yumi only when asked to take it
  task automatic take_miss(input logic accept);
    int tries;
    begin
      tries = 0;
      while (!seen_req_v)
        begin
          if (tries == WAIT_LIMIT)
            wait_expired("miss request");
          step();
          tries++;
        end
      req_way = cache_req_o.repl_way;
      if (accept)
        cache_req_yumi_i = 1'b1;
      step();
    end
  endtask

  task automatic finish_miss;
    int tries;
    begin
      repeat (3) step();
      cache_req_complete_i = 1'b1;
      step();
      tries = 0;
      while (!seen_ready)
        begin
          if (tries == WAIT_LIMIT)
            wait_expired("ready_o after the miss completed");
          step();
          tries++;
        end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
    begin
      icache_pkg::index_t set_idx;
      icache_pkg::ptag_t  set_tag [icache_pkg::ASSOC];
      icache_pkg::ptag_t  new_tag;
      logic [31:0]        rnd;

      seed                 = 52737;
      reset_i              = 1'b1;
      vaddr_i              = '0;
      v_i                  = 1'b0;
      ptag_i               = '0;
      ptag_v_i             = 1'b0;
      cache_req_yumi_i     = 1'b0;
      cache_req_busy_i     = 1'b0;
      cache_req_complete_i = 1'b0;
      tag_pkt_i            = '0;
      tag_pkt_v_i          = 1'b0;
      data_pkt_i           = '0;
      data_pkt_v_i         = 1'b0;
      fetch_ptag           = '0;
      fetch_ptag_v         = 1'b0;
      tl_rec               = '0;
      tv_rec               = '0;
      exp_data_v           = 1'b0;
      exp_miss_v           = 1'b0;
      exp_word             = '0;
      exp_paddr            = '0;
      exp_repl             = '0;
      seen_req_v           = 1'b0;
      seen_ready           = 1'b0;
      model_miss           = 1'b0;
      for (int s = 0; s < icache_pkg::SETS; s++)
        begin
          lru_root[s]    = 1'b0;
          lru_node[s][0] = 1'b0;
          lru_node[s][1] = 1'b0;
          for (int w = 0; w < icache_pkg::ASSOC; w++)
            model_valid[s][w] = 1'b0;
        end

      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      // Idle after reset
      repeat (2) step();

      // Cold miss, then the miss state until complete
      rnd     = $random(seed);
      set_idx = rnd[3:0];
      for (int w = 0; w < icache_pkg::ASSOC; w++)
        begin
          rnd        = $random(seed);
          set_tag[w] = {1'b0, rnd[4:0], icache_pkg::way_t'(w)};
        end
      issue_fetch(set_idx, 2'd1, set_tag[0], 1'b1);
      take_miss(1'b1);
      finish_miss();

      // Fill all four ways and read every word back to back
      for (int w = 0; w < icache_pkg::ASSOC; w++)
        begin
          write_tag(icache_pkg::e_tag_set, set_idx, icache_pkg::way_t'(w), set_tag[w]);
          fill_random(set_idx, icache_pkg::way_t'(w));
        end
      for (int w = 0; w < icache_pkg::ASSOC; w++)
        for (int o = 0; o < icache_pkg::ASSOC; o++)
          issue_fetch(set_idx, icache_pkg::offset_t'(o), set_tag[w], 1'b1);
      repeat (3) step();

      // Hits steer the tree and a new tag picks the victim
      for (int n = 0; n < 6; n++)
        begin
          rnd = $random(seed);
          issue_fetch(set_idx, rnd[5:4], set_tag[rnd[1:0]], 1'b1);
        end
      rnd     = $random(seed);
      new_tag = {1'b1, rnd[6:0]};
      issue_fetch(set_idx, rnd[9:8], new_tag, 1'b1);
      take_miss(1'b1);
      finish_miss();
      write_tag(icache_pkg::e_tag_set, set_idx, req_way, new_tag);
      fill_random(set_idx, req_way);
      set_tag[req_way] = new_tag;
      issue_fetch(set_idx, rnd[11:10], new_tag, 1'b1);
      repeat (3) step();

      // Engine writes held off by a fetch in the same cycle
      tag_pkt_i.opcode = icache_pkg::e_tag_clear;
      tag_pkt_i.index  = set_idx;
      tag_pkt_i.way_id = 2'd1;
      tag_pkt_v_i      = 1'b1;
      data_pkt_v_i     = 1'b1;
      issue_fetch(set_idx, 2'd0, set_tag[1], 1'b1);
      repeat (3) step();

      // Cleared way misses; request left unaccepted
      write_tag(icache_pkg::e_tag_clear, set_idx, 2'd1, '0);
      issue_fetch(set_idx, 2'd3, set_tag[1], 1'b1);
      take_miss(1'b0);
      issue_fetch(set_idx, 2'd0, set_tag[0], 1'b0);
      repeat (3) step();

      // Busy engine holds off new fetches
      cache_req_busy_i = 1'b1;
      for (int n = 0; n < 4; n++)
        issue_fetch(set_idx, icache_pkg::offset_t'(n), set_tag[2], 1'b1);
      cache_req_busy_i = 1'b0;
      issue_fetch(set_idx, 2'd2, set_tag[2], 1'b1);
      repeat (3) step();

      $display("*** TEST PASSED ***");
      $finish;
    end

endmodule

`default_nettype wire
